// File: all.f
+incdir+src
src/crtcRegPkg.sv
src/crtcTimingPkg.sv
src/crtcIfs.sv
src/crtcRegs.sv
src/crtcHorz.sv
src/crtcVert.sv
src/crtcAddrCursor.sv
src/crtcTop.sv
tests/crtcTb.sv

// File: tests/crtc_cases.txt
# name, sixteen register bytes in hex (R0 to R15), then expected decimal values:
# line period, hsync width, disen width, frame lines, vsync width, cursor lines
steadyBasic 27 20 22 34 09 02 06 07 00 03 01 02 01 00 C1 45 40 4 32 42 3 2
skewTwoWrap 1D 14 17 23 07 00 04 05 A0 04 00 04 3F F0 80 07 30 3 20 40 2 5
cursorOff 31 28 2A 46 05 03 03 04 10 07 21 06 08 00 08 05 50 6 40 51 4 0
singleLineRows 0F 08 0A 11 13 01 0C 0E 40 00 00 00 00 00 40 1A 16 1 8 21 1 1

// File: tests/crtcTb.sv
`timescale 1ns/1ps
`include "crtc_defines.svh"

module crtcTb;
	localparam integer sigHsync = 0;
	localparam integer sigVsync = 1;
	localparam integer sigDisen = 2;
	localparam integer waitLimit = 100000;

	logic CLK;
	logic nRESET;
	logic crtcEn;
	logic cs;
	logic rnw;
	logic a0;
	crtcRegPkg::regByte_t dataIn;
	crtcRegPkg::regByte_t dataOut;
	logic hsync;
	logic vsync;
	logic disen;
	logic cursor;
	crtcRegPkg::memAddr_t framestoreAdr;
	crtcRegPkg::rowAddr_t rowAddress;

	string caseName;
	crtcRegPkg::regByte_t regVal [`CRTC_NUM_REGS];
	integer expValue [6];
	integer clkCount;

	crtcTop uut (.CLK(CLK), .nRESET(nRESET), .crtcEn(crtcEn), .cs(cs), .rnw(rnw), .a0(a0),
		.dataIn(dataIn), .dataOut(dataOut), .hsync(hsync), .vsync(vsync), .disen(disen),
		.cursor(cursor), .framestoreAdr(framestoreAdr), .rowAddress(rowAddress));

	always #4 CLK = !CLK;

	// Character clock at half the clock rate
	always @(posedge CLK) begin
		crtcEn <= !crtcEn;
		clkCount <= clkCount + 1;
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic checkByte(input string what, input crtcRegPkg::regByte_t want,
		input crtcRegPkg::regByte_t got);
		if (got !== want)
			abortRun($sformatf("ERROR %s %s: expected %0h, actual %0h", caseName, what, want, got));
	endtask

	task automatic checkAddr(input string what, input crtcRegPkg::memAddr_t want,
		input crtcRegPkg::memAddr_t got);
		if (got !== want)
			abortRun($sformatf("ERROR %s %s: expected %0h, actual %0h", caseName, what, want, got));
	endtask

	task automatic checkRow(input string what, input crtcRegPkg::rowAddr_t want,
		input crtcRegPkg::rowAddr_t got);
		if (got !== want)
			abortRun($sformatf("ERROR %s %s: expected %0d, actual %0d", caseName, what, want, got));
	endtask

	task automatic checkCount(input string what, input integer want, input integer got);
		if (got !== want)
			abortRun($sformatf("ERROR %s %s: expected %0d, actual %0d", caseName, what, want, got));
	endtask

	function automatic logic probe(input integer sel);
		case (sel)
			sigHsync: return hsync;
			sigVsync: return vsync;
			default: return disen;
		endcase
	endfunction

	// Outputs settle after the rising edge, so look at them on the falling edge
	task automatic waitLevel(input integer sel, input logic level, input string sigName);
		integer waited;
		waited = 0;
		@(negedge CLK);
		while (probe(sel) !== level && waited < waitLimit) begin
			@(negedge CLK);
			waited = waited + 1;
		end
		if (probe(sel) !== level)
			abortRun($sformatf("Timed out waiting for %s to go %s in case %s", sigName,
				level ? "high" : "low", caseName));
	endtask

	task automatic waitRise(input integer sel, input string sigName, output integer stamp);
		waitLevel(sel, 1'b0, sigName);
		waitLevel(sel, 1'b1, sigName);
		stamp = clkCount;
	endtask

	task automatic hostAccess(input logic readNotWrite, input logic sel,
		input crtcRegPkg::regByte_t value);
		@(posedge CLK);
		cs <= 1'b1;
		rnw <= readNotWrite;
		a0 <= sel;
		dataIn <= value;
		@(posedge CLK);
		cs <= 1'b0;
		rnw <= 1'b1;
	endtask

	task automatic readBack(input crtcRegPkg::regIndex_t index,
		output crtcRegPkg::regByte_t value);
		hostAccess(1'b0, 1'b0, {3'b000, index});
		hostAccess(1'b1, 1'b1, 8'h00);
		@(negedge CLK);
		value = dataOut;
	endtask

	function automatic crtcRegPkg::memAddr_t regAddr(input integer hiIndex);
		return {regVal[hiIndex][5:0], regVal[hiIndex + 1]};
	endfunction

	// Scan from one vsync rise to the next and check every displayed line and cursor hit
	task automatic scanFrame(output integer fall, output integer v2, output integer cursorLines);
		integer waited;
		integer lines;
		integer perRow;
		logic prevVsync;
		logic prevDisen;
		logic prevCursor;
		waited = 0;
		lines = 0;
		cursorLines = 0;
		fall = -1;
		v2 = -1;
		perRow = regVal[`CRTC_REG_MAXSCAN][4:0] + 1;
		prevVsync = 1'b1;
		prevDisen = disen;
		prevCursor = cursor;
		while (v2 < 0 && waited < waitLimit) begin
			@(negedge CLK);
			waited = waited + 1;
			if (!vsync && prevVsync)
				fall = clkCount;
			if (vsync && !prevVsync)
				v2 = clkCount;
			if (disen && !prevDisen) begin
				checkRow("row address", lines % perRow, rowAddress);
				checkAddr("line start address", regAddr(`CRTC_REG_START_HI)
					+ (lines / perRow) * regVal[`CRTC_REG_HDISP]
					+ regVal[`CRTC_REG_MODE][5:4], framestoreAdr);
				lines = lines + 1;
			end
			if (cursor && !prevCursor) begin
				checkAddr("cursor address", regAddr(`CRTC_REG_CURSOR_HI)
					+ regVal[`CRTC_REG_MODE][7:6], framestoreAdr);
				cursorLines = cursorLines + 1;
			end
			prevVsync = vsync;
			prevDisen = disen;
			prevCursor = cursor;
		end
		if (v2 < 0)
			abortRun($sformatf("Timed out waiting for the next vsync in case %s", caseName));
		else
			checkCount("displayed lines", regVal[`CRTC_REG_VDISP][6:0] * perRow, lines);
	endtask

	task automatic runCase();
		integer t0;
		integer t1;
		integer t2;
		integer v0;
		integer v1;
		integer v2;
		integer d0;
		integer cursorLines;
		integer lineClocks;
		crtcRegPkg::regByte_t readValue;
		for (int i = 0; i < `CRTC_NUM_REGS; i++) begin
			hostAccess(1'b0, 1'b0, crtcRegPkg::regByte_t'(i));
			hostAccess(1'b0, 1'b1, regVal[i]);
		end
		readBack(`CRTC_REG_CURSOR_HI, readValue);
		checkByte("cursor high readback", regVal[`CRTC_REG_CURSOR_HI] & 8'h3f, readValue);
		readBack(`CRTC_REG_CURSOR_LO, readValue);
		checkByte("cursor low readback", regVal[`CRTC_REG_CURSOR_LO], readValue);
		readBack(`CRTC_REG_SYNCWIDTH, readValue);
		checkByte("sync width readback", 8'h00, readValue);
		// Let the frame restarted by the register writes reach vsync
		waitRise(sigVsync, "vsync", v0);
		waitRise(sigHsync, "hsync", t0);
		waitLevel(sigHsync, 1'b0, "hsync");
		t1 = clkCount;
		waitRise(sigHsync, "hsync", t2);
		checkCount("line period", expValue[0], (t2 - t0) / 2);
		checkCount("hsync width", expValue[1], (t1 - t0) / 2);
		waitRise(sigDisen, "disen", d0);
		waitLevel(sigDisen, 1'b0, "disen");
		checkCount("disen width", expValue[2], (clkCount - d0) / 2);
		waitRise(sigVsync, "vsync", v0);
		scanFrame(v1, v2, cursorLines);
		lineClocks = 2 * (regVal[`CRTC_REG_HTOTAL] + 1);
		checkCount("frame lines", expValue[3], (v2 - v0) / lineClocks);
		checkCount("vsync width", expValue[4], (v1 - v0) / lineClocks);
		checkCount("cursor lines", expValue[5], cursorLines);
	endtask

	initial begin
		integer fd;
		integer n;
		integer caseCount;
		logic badLine;
		logic [8*200-1:0] lineBuf;
		CLK = 1'b0;
		nRESET = 1'b0;
		crtcEn = 1'b0;
		cs = 1'b0;
		rnw = 1'b1;
		a0 = 1'b0;
		dataIn = '0;
		clkCount = 0;
		caseCount = 0;
		badLine = 1'b0;
		caseName = "reset";
		repeat (16) @(posedge CLK);
		nRESET <= 1'b1;
		fd = $fopen("tests/crtc_cases.txt", "r");
		if (fd == 0)
			abortRun("Could not open the case file tests/crtc_cases.txt");
		else begin
			while (!$feof(fd) && !badLine) begin
				lineBuf = '0;
				n = $fgets(lineBuf, fd);
				n = $sscanf(lineBuf,
					"%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d %d %d %d %d %d",
					caseName, regVal[0], regVal[1], regVal[2], regVal[3], regVal[4],
					regVal[5], regVal[6], regVal[7], regVal[8], regVal[9], regVal[10],
					regVal[11], regVal[12], regVal[13], regVal[14], regVal[15],
					expValue[0], expValue[1], expValue[2], expValue[3], expValue[4],
					expValue[5]);
				if (n == 23 && caseName[0] != "#") begin
					runCase();
					caseCount = caseCount + 1;
				end else if (n > 0 && caseName[0] != "#") begin
					badLine = 1'b1;
				end
			end
			$fclose(fd);
			if (badLine || caseCount == 0)
				abortRun("The case file has a malformed line or holds no cases");
			else begin
				$display("Everything OK");
				$finish;
			end
		end
	end
endmodule

// File: src/crtcTop.sv
`timescale 1ns/1ps

module crtcTop (
	input  logic CLK,
	input  logic nRESET,
	input  logic crtcEn,
	input  logic cs,
	input  logic rnw,
	input  logic a0,
	input  crtcRegPkg::regByte_t dataIn,
	output crtcRegPkg::regByte_t dataOut,
	output logic hsync,
	output logic vsync,
	output logic disen,
	output logic cursor,
	output crtcRegPkg::memAddr_t framestoreAdr,
	output crtcRegPkg::rowAddr_t rowAddress
);
	crtcCfgIf cfg();
	crtcScanIf scan();

	// Host side
	crtcRegs regs (.CLK(CLK), .nRESET(nRESET), .cs(cs), .rnw(rnw), .a0(a0),
		.dataIn(dataIn), .dataOut(dataOut), .cfg(cfg.regs));

	// Timing chain
	crtcHorz horz (.CLK(CLK), .nRESET(nRESET), .crtcEn(crtcEn),
		.cfg(cfg.timing), .scan(scan.horz), .hsync(hsync));

	crtcVert vert (.CLK(CLK), .nRESET(nRESET), .crtcEn(crtcEn),
		.cfg(cfg.timing), .scan(scan.vert), .vsync(vsync));

	crtcAddrCursor addrCursor (.CLK(CLK), .nRESET(nRESET), .crtcEn(crtcEn),
		.cfg(cfg.timing), .scan(scan.addr), .framestoreAdr(framestoreAdr),
		.disen(disen), .cursor(cursor));

	assign rowAddress = scan.rowAddress;
endmodule

// File: src/crtcAddrCursor.sv
`timescale 1ns/1ps
`include "crtc_defines.svh"

module crtcAddrCursor (
	input  logic CLK,
	input  logic nRESET,
	input  logic crtcEn,
	crtcCfgIf.timing cfg,
	crtcScanIf.addr scan,
	output crtcRegPkg::memAddr_t framestoreAdr,
	output logic disen,
	output logic cursor
);
	crtcRegPkg::memAddr_t lineBase;
	crtcRegPkg::memAddr_t nextBase;
	logic [5:0] blinkCount;
	logic cursorOn;
	logic rawDisen;
	logic rawCursor;
	logic [1:0] disenPipe;
	logic [1:0] cursorPipe;

	// Pick the raw value or one of the two delayed copies
	function automatic logic skewSelect(crtcTimingPkg::skew_t sel, logic raw, logic [1:0] pipe);
		case (sel)
			2'd0: return raw;
			2'd1: return pipe[0];
			default: return pipe[1];
		endcase
	endfunction

	assign nextBase = lineBase + crtcRegPkg::memAddr_t'(cfg.horzDisplay);
	assign rawDisen = scan.hDisplay && scan.vDisplay;
	// Cursor only inside the visible area
	assign rawCursor = rawDisen && cursorOn && (framestoreAdr == cfg.cursorAdr)
		&& (scan.rowAddress >= cfg.cursorStart) && (scan.rowAddress <= cfg.cursorEnd);
	assign disen = skewSelect(cfg.displayMode[5:4], rawDisen, disenPipe);
	assign cursor = skewSelect(cfg.displayMode[7:6], rawCursor, cursorPipe);

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			framestoreAdr <= '0;
			lineBase <= '0;
		end else if (crtcEn) begin
			if (scan.newScreen) begin
				framestoreAdr <= cfg.startAdr;
				lineBase <= cfg.startAdr;
			end else if (scan.newRow) begin
				framestoreAdr <= nextBase;
				lineBase <= nextBase;
			end else if (scan.newLine) begin
				framestoreAdr <= lineBase;
			end else begin
				framestoreAdr <= framestoreAdr + 14'd1;
			end
		end
	end

	// Blink state and skew pipelines
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			blinkCount <= '0;
			cursorOn <= 1'b0;
			disenPipe <= '0;
			cursorPipe <= '0;
		end else if (crtcEn) begin
			if (scan.newScreen) begin
				blinkCount <= blinkCount + 6'd1;
				case (cfg.blinkMode)
					crtcRegPkg::blinkSteady: cursorOn <= 1'b1;
					crtcRegPkg::blinkOff: cursorOn <= 1'b0;
					crtcRegPkg::blinkFast: cursorOn <= blinkCount[`CRTC_BLINK_FAST_BIT];
					default: cursorOn <= blinkCount[`CRTC_BLINK_SLOW_BIT];
				endcase
			end
			disenPipe <= {disenPipe[0], rawDisen};
			cursorPipe <= {cursorPipe[0], rawCursor};
		end
	end
endmodule

// File: src/crtcVert.sv
`timescale 1ns/1ps

module crtcVert (
	input  logic CLK,
	input  logic nRESET,
	input  logic crtcEn,
	crtcCfgIf.timing cfg,
	crtcScanIf.vert scan,
	output logic vsync
);
	crtcRegPkg::vCount_t rowCount;
	crtcRegPkg::vCount_t nextRowCount;
	crtcRegPkg::rowAddr_t adjCount;
	crtcRegPkg::pulseWidth_t pulseCount;
	crtcTimingPkg::vState_t vState;
	logic inAdjust;
	logic lastRow;
	logic frameRowEnd;
	logic adjDone;
	logic resetPending;
	logic restart;

	assign restart = cfg.vReset || resetPending;
	assign lastRow = scan.rowAddress == cfg.maxScanline;
	assign frameRowEnd = lastRow && (rowCount >= cfg.vertTotal);
	assign adjDone = (adjCount + 5'd1) == cfg.vertTotalAdj;
	// Row boundaries stop counting during the adjust lines
	assign scan.newRow = scan.newLine && lastRow && !inAdjust;
	assign scan.newScreen = restart || (scan.newLine && (inAdjust ? adjDone
		: frameRowEnd && cfg.vertTotalAdj == '0));
	assign nextRowCount = rowCount + {6'b0, scan.newRow};
	assign scan.vDisplay = vState == crtcTimingPkg::vDisp;
	assign vsync = vState == crtcTimingPkg::vPulse;

	always_ff @(posedge CLK) begin
		if (!nRESET)
			resetPending <= 1'b0;
		else if (crtcEn)
			resetPending <= 1'b0;
		else if (cfg.vReset)
			resetPending <= 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			scan.rowAddress <= '0;
			rowCount <= '0;
			adjCount <= '0;
			inAdjust <= 1'b0;
			pulseCount <= '0;
			vState <= crtcTimingPkg::vBack;
		end else if (crtcEn) begin
			if (scan.newScreen) begin
				scan.rowAddress <= '0;
				rowCount <= '0;
				adjCount <= '0;
				inAdjust <= 1'b0;
				pulseCount <= '0;
				vState <= (cfg.vertDisplay == '0) ? crtcTimingPkg::vFront : crtcTimingPkg::vDisp;
			end else if (scan.newLine) begin
				scan.rowAddress <= scan.newRow ? '0 : scan.rowAddress + 5'd1;
				rowCount <= nextRowCount;
				// Adjust lines start after the last row of the last character row
				inAdjust <= inAdjust || frameRowEnd;
				adjCount <= inAdjust ? adjCount + 5'd1 : '0;
				case (vState)
					crtcTimingPkg::vDisp:
						if (nextRowCount == cfg.vertDisplay)
							vState <= crtcTimingPkg::vFront;
					crtcTimingPkg::vFront:
						if (nextRowCount == cfg.vertSyncPos) begin
							vState <= (cfg.vSyncWidth != '0) ? crtcTimingPkg::vPulse
								: crtcTimingPkg::vBack;
							pulseCount <= 4'd1;
						end
					crtcTimingPkg::vPulse:
						if (pulseCount == cfg.vSyncWidth)
							vState <= crtcTimingPkg::vBack;
						else
							pulseCount <= pulseCount + 4'd1;
					default: ;
				endcase
			end
		end
	end
endmodule

// File: src/crtcHorz.sv
`timescale 1ns/1ps

module crtcHorz (
	input  logic CLK,
	input  logic nRESET,
	input  logic crtcEn,
	crtcCfgIf.timing cfg,
	crtcScanIf.horz scan,
	output logic hsync
);
	crtcRegPkg::regByte_t charCount;
	crtcRegPkg::regByte_t nextCount;
	crtcRegPkg::pulseWidth_t pulseCount;
	crtcTimingPkg::hState_t hState;
	logic resetPending;
	logic restart;

	assign restart = cfg.hReset || resetPending;
	assign scan.newLine = (charCount == cfg.horzTotal) || restart;
	assign nextCount = scan.newLine ? '0 : charCount + 8'd1;
	assign scan.hDisplay = hState == crtcTimingPkg::hDisp;
	assign hsync = hState == crtcTimingPkg::hPulse;

	// Host pulse may land between character times
	always_ff @(posedge CLK) begin
		if (!nRESET)
			resetPending <= 1'b0;
		else if (crtcEn)
			resetPending <= 1'b0;
		else if (cfg.hReset)
			resetPending <= 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			charCount <= '0;
			pulseCount <= '0;
			hState <= crtcTimingPkg::hBack;
		end else if (crtcEn) begin
			charCount <= nextCount;
			if (scan.newLine) begin
				// Empty display area skips straight to the front porch
				hState <= (cfg.horzDisplay == '0) ? crtcTimingPkg::hFront : crtcTimingPkg::hDisp;
				pulseCount <= '0;
			end else begin
				case (hState)
					crtcTimingPkg::hDisp:
						if (nextCount == cfg.horzDisplay)
							hState <= crtcTimingPkg::hFront;
					crtcTimingPkg::hFront:
						if (nextCount == cfg.horzSyncPos) begin
							hState <= (cfg.hSyncWidth != '0) ? crtcTimingPkg::hPulse
								: crtcTimingPkg::hBack;
							pulseCount <= 4'd1;
						end
					crtcTimingPkg::hPulse:
						if (pulseCount == cfg.hSyncWidth)
							hState <= crtcTimingPkg::hBack;
						else
							pulseCount <= pulseCount + 4'd1;
					default: ;
				endcase
			end
		end
	end
endmodule

// File: src/crtcRegs.sv
`timescale 1ns/1ps
`include "crtc_defines.svh"

module crtcRegs (
	input  logic CLK,
	input  logic nRESET,
	input  logic cs,
	input  logic rnw,
	input  logic a0,
	input  crtcRegPkg::regByte_t dataIn,
	output crtcRegPkg::regByte_t dataOut,
	crtcCfgIf.regs cfg
);
	crtcRegPkg::regIndex_t regSel;
	logic hostWrite;
	logic hostRead;

	assign hostWrite = cs && !rnw;
	assign hostRead = cs && rnw && a0;

	// Select register and register file
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			regSel <= '0;
			cfg.horzTotal <= '0;
			cfg.horzDisplay <= '0;
			cfg.horzSyncPos <= '0;
			cfg.hSyncWidth <= '0;
			cfg.vSyncWidth <= '0;
			cfg.vertTotal <= '0;
			cfg.vertTotalAdj <= '0;
			cfg.vertDisplay <= '0;
			cfg.vertSyncPos <= '0;
			cfg.displayMode <= '0;
			cfg.maxScanline <= '0;
			cfg.blinkMode <= crtcRegPkg::blinkSteady;
			cfg.cursorStart <= '0;
			cfg.cursorEnd <= '0;
			cfg.startAdr <= '0;
			cfg.cursorAdr <= '0;
		end else if (hostWrite && !a0) begin
			regSel <= dataIn[4:0];
		end else if (hostWrite) begin
			case (regSel)
				`CRTC_REG_HTOTAL: cfg.horzTotal <= dataIn;
				`CRTC_REG_HDISP: cfg.horzDisplay <= dataIn;
				`CRTC_REG_HSYNCPOS: cfg.horzSyncPos <= dataIn;
				`CRTC_REG_SYNCWIDTH: begin
					// Vertical width in the high nibble
					cfg.hSyncWidth <= dataIn[3:0];
					cfg.vSyncWidth <= dataIn[7:4];
				end
				`CRTC_REG_VTOTAL: cfg.vertTotal <= dataIn[6:0];
				`CRTC_REG_VTOTALADJ: cfg.vertTotalAdj <= dataIn[4:0];
				`CRTC_REG_VDISP: cfg.vertDisplay <= dataIn[6:0];
				`CRTC_REG_VSYNCPOS: cfg.vertSyncPos <= dataIn[6:0];
				`CRTC_REG_MODE: cfg.displayMode <= dataIn;
				`CRTC_REG_MAXSCAN: cfg.maxScanline <= dataIn[4:0];
				`CRTC_REG_CURSOR_START: begin
					cfg.blinkMode <= crtcRegPkg::blinkMode_t'(dataIn[6:5]);
					cfg.cursorStart <= dataIn[4:0];
				end
				`CRTC_REG_CURSOR_END: cfg.cursorEnd <= dataIn[4:0];
				`CRTC_REG_START_HI: cfg.startAdr[13:8] <= dataIn[5:0];
				`CRTC_REG_START_LO: cfg.startAdr[7:0] <= dataIn;
				`CRTC_REG_CURSOR_HI: cfg.cursorAdr[13:8] <= dataIn[5:0];
				`CRTC_REG_CURSOR_LO: cfg.cursorAdr[7:0] <= dataIn;
				default: ;
			endcase
		end
	end

	// Timing restarts one clock after a horizontal or vertical register write
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			cfg.hReset <= 1'b0;
			cfg.vReset <= 1'b0;
		end else begin
			cfg.hReset <= hostWrite && a0 && regSel <= `CRTC_REG_SYNCWIDTH;
			cfg.vReset <= hostWrite && a0 && regSel >= `CRTC_REG_VTOTAL
				&& regSel <= `CRTC_REG_VSYNCPOS;
		end
	end

	// Only the cursor address reads back
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			dataOut <= '0;
		end else if (hostRead) begin
			case (regSel)
				`CRTC_REG_CURSOR_HI: dataOut <= {2'b00, cfg.cursorAdr[13:8]};
				`CRTC_REG_CURSOR_LO: dataOut <= cfg.cursorAdr[7:0];
				default: dataOut <= '0;
			endcase
		end
	end
endmodule

// File: src/crtcIfs.sv
`timescale 1ns/1ps

// Configuration registers and timing restart pulses
interface crtcCfgIf;
	crtcRegPkg::regByte_t horzTotal;
	crtcRegPkg::regByte_t horzDisplay;
	crtcRegPkg::regByte_t horzSyncPos;
	crtcRegPkg::pulseWidth_t hSyncWidth;
	crtcRegPkg::pulseWidth_t vSyncWidth;
	crtcRegPkg::vCount_t vertTotal;
	crtcRegPkg::rowAddr_t vertTotalAdj;
	crtcRegPkg::vCount_t vertDisplay;
	crtcRegPkg::vCount_t vertSyncPos;
	crtcRegPkg::regByte_t displayMode;
	crtcRegPkg::rowAddr_t maxScanline;
	crtcRegPkg::blinkMode_t blinkMode;
	crtcRegPkg::rowAddr_t cursorStart;
	crtcRegPkg::rowAddr_t cursorEnd;
	crtcRegPkg::memAddr_t startAdr;
	crtcRegPkg::memAddr_t cursorAdr;
	logic hReset;
	logic vReset;

	modport regs (output horzTotal, horzDisplay, horzSyncPos, hSyncWidth, vSyncWidth,
		vertTotal, vertTotalAdj, vertDisplay, vertSyncPos, displayMode, maxScanline,
		blinkMode, cursorStart, cursorEnd, startAdr, cursorAdr, hReset, vReset);
	modport timing (input horzTotal, horzDisplay, horzSyncPos, hSyncWidth, vSyncWidth,
		vertTotal, vertTotalAdj, vertDisplay, vertSyncPos, displayMode, maxScanline,
		blinkMode, cursorStart, cursorEnd, startAdr, cursorAdr, hReset, vReset);
endinterface

// Line and frame events shared by the timing blocks
interface crtcScanIf;
	logic newLine;
	logic newRow;
	logic newScreen;
	logic hDisplay;
	logic vDisplay;
	crtcRegPkg::rowAddr_t rowAddress;

	modport horz (output newLine, hDisplay);
	modport vert (input newLine, output newRow, newScreen, vDisplay, rowAddress);
	modport addr (input newLine, newRow, newScreen, hDisplay, vDisplay, rowAddress);
endinterface

// File: src/crtcTimingPkg.sv
package crtcTimingPkg;

	// Horizontal phases within one scanline
	typedef enum logic [1:0] {
		hDisp,
		hFront,
		hPulse,
		hBack
	} hState_t;

	// Vertical phases within one frame
	typedef enum logic [1:0] {
		vDisp,
		vFront,
		vPulse,
		vBack
	} vState_t;

	// Output delay of 0, 1 or 2 character times
	typedef logic [1:0] skew_t;

endpackage

// File: src/crtcRegPkg.sv
package crtcRegPkg;

	// Host data byte
	typedef logic [7:0] regByte_t;

	// Register select, only 16 of 32 codes are mapped
	typedef logic [4:0] regIndex_t;

	// Framestore, start and cursor addresses
	typedef logic [13:0] memAddr_t;

	// Scanline within a character row
	typedef logic [4:0] rowAddr_t;

	// Character rows per frame
	typedef logic [6:0] vCount_t;

	// Sync pulse width in characters or scanlines
	typedef logic [3:0] pulseWidth_t;

	// Cursor mode from bits 6:5 of the cursor start register
	typedef enum logic [1:0] {
		blinkSteady,
		blinkOff,
		blinkFast,
		blinkSlow
	} blinkMode_t;

endpackage

// File: src/crtc_defines.svh
`ifndef CRTC_DEFINES_SVH
`define CRTC_DEFINES_SVH

// Register indices as seen by the host select register
`define CRTC_REG_HTOTAL       5'd0
`define CRTC_REG_HDISP        5'd1
`define CRTC_REG_HSYNCPOS     5'd2
`define CRTC_REG_SYNCWIDTH    5'd3
`define CRTC_REG_VTOTAL       5'd4
`define CRTC_REG_VTOTALADJ    5'd5
`define CRTC_REG_VDISP        5'd6
`define CRTC_REG_VSYNCPOS     5'd7
`define CRTC_REG_MODE         5'd8
`define CRTC_REG_MAXSCAN      5'd9
`define CRTC_REG_CURSOR_START 5'd10
`define CRTC_REG_CURSOR_END   5'd11
`define CRTC_REG_START_HI     5'd12
`define CRTC_REG_START_LO     5'd13
`define CRTC_REG_CURSOR_HI    5'd14
`define CRTC_REG_CURSOR_LO    5'd15
`define CRTC_NUM_REGS         16

// Frame counter bits that drive the two blink rates
`define CRTC_BLINK_FAST_BIT   4
`define CRTC_BLINK_SLOW_BIT   5

`endif
